// File: logic/memmap_pkg.sv
`default_nettype none

package memmap_pkg;

    // UART transmitter window
    localparam logic [31:0] uart_tx_base = 32'hf000_0000;
    localparam logic [31:0] uart_tx_end = 32'hf000_000f;

    // machine timer window
    localparam logic [31:0] timer_base = 32'hffff_ff00;
    localparam logic [31:0] timer_end = 32'hffff_ff0f;

    // timer register offsets inside its window
    localparam logic [3:0] mtime_lo_off = 4'd0;
    localparam logic [3:0] mtime_hi_off = 4'd4;
    localparam logic [3:0] mtimecmp_lo_off = 4'd8;
    localparam logic [3:0] mtimecmp_hi_off = 4'd12;

    // everything outside the two windows falls to memory
    typedef enum logic [1:0] {
        region_memory,
        region_uart_tx,
        region_timer
    } mmio_region_e;

endpackage

`default_nettype wire

// File: logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // single word command from the core side
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [31:0] wdata;
    } bus_cmd_t;

    // read data, valid for one cycle per read
    typedef struct packed {
        logic [31:0] rdata;
        logic        rdata_valid;
    } bus_rsp_t;

endpackage

`default_nettype wire

// File: logic/memory_map_controller.sv
`timescale 1ns/10ps
`default_nettype none

module memory_map_controller (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              cmd_start,
    input  bus_pkg::bus_cmd_t cmd,
    output logic              cmd_ready,
    output bus_pkg::bus_rsp_t rsp,

    output logic              mem_start,
    output bus_pkg::bus_cmd_t mem_cmd,
    input  logic              mem_ready,
    input  bus_pkg::bus_rsp_t mem_rsp,

    output logic              uart_start,
    output bus_pkg::bus_cmd_t uart_cmd,
    input  logic              uart_ready,
    input  bus_pkg::bus_rsp_t uart_rsp,

    output logic              timer_start,
    output bus_pkg::bus_cmd_t timer_cmd,
    input  logic              timer_ready,
    input  bus_pkg::bus_rsp_t timer_rsp
);

    import memmap_pkg::*;

    mmio_region_e live_region;
    mmio_region_e saved_region;
    logic         accept;

    // decode of the address on the port right now
    always_comb begin
        if (cmd.addr >= uart_tx_base && cmd.addr <= uart_tx_end) begin
            live_region = region_uart_tx;
        end else if (cmd.addr >= timer_base && cmd.addr <= timer_end) begin
            live_region = region_timer;
        end else begin
            live_region = region_memory;
        end
    end

    // a start while busy never reaches a target
    assign accept = cmd_start && cmd_ready;

    assign mem_start = accept && (live_region == region_memory);
    assign uart_start = accept && (live_region == region_uart_tx);
    assign timer_start = accept && (live_region == region_timer);

    // io targets see window-relative addresses
    always_comb begin
        mem_cmd = cmd;
        uart_cmd = cmd;
        uart_cmd.addr = cmd.addr - uart_tx_base;
        timer_cmd = cmd;
        timer_cmd.addr = cmd.addr - timer_base;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            saved_region <= region_memory;
        end else if (accept) begin
            saved_region <= live_region;
        end
    end

    // ready and response follow the region of the last accepted command,
    // so a new address on the port cannot steal an older response
    always_comb begin
        case (saved_region)
            region_uart_tx: begin
                cmd_ready = uart_ready;
                rsp = uart_rsp;
            end
            region_timer: begin
                cmd_ready = timer_ready;
                rsp = timer_rsp;
            end
            default: begin
                cmd_ready = mem_ready;
                rsp = mem_rsp;
            end
        endcase
    end

    // every response belongs to a read accepted one cycle earlier
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp.rdata_valid |-> $past(accept && !cmd.write));

    // one command in flight, so no target is still busy when a new one goes out
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_start || uart_start || timer_start) |->
            (mem_ready && uart_ready && timer_ready));

endmodule

`default_nettype wire

// File: logic/data_memory.sv
`timescale 1ns/10ps
`default_nettype none

module data_memory #(
    parameter int memory_words = 1024
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  bus_pkg::bus_cmd_t cmd,
    output logic              ready,
    output bus_pkg::bus_rsp_t rsp
);

    localparam int addr_bits = $clog2(memory_words);

    logic [31:0]          mem [memory_words];
    logic [addr_bits-1:0] word_idx;
    logic [31:0]          rdata_q;
    logic                 valid_q;

    // byte offset dropped, upper bits wrap
    assign word_idx = cmd.addr[addr_bits+1:2];

    assign ready = 1'b1;

    always_ff @(posedge clk) begin
        if (start && cmd.write) begin
            mem[word_idx] <= cmd.wdata;
        end
        if (start && !cmd.write) begin
            rdata_q <= mem[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= start && !cmd.write;
        end
    end

    assign rsp = '{rdata: rdata_q, rdata_valid: valid_q};

    // controller must hand over a known word index on every start
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !$isunknown(word_idx));

endmodule

`default_nettype wire

// File: logic/uart_tx_port.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx_port #(
    parameter int clks_per_bit = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  bus_pkg::bus_cmd_t cmd,
    output logic              ready,
    output bus_pkg::bus_rsp_t rsp,
    output logic              uart_tx
);

    localparam int cnt_bits = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

    tx_state_e           state_q;
    logic [cnt_bits-1:0] bit_cnt_q;
    logic [2:0]          bit_idx_q;
    logic [7:0]          shift_q;
    logic [7:0]          last_byte_q;
    logic                tx_q;
    logic                valid_q;
    logic                bit_done;
    logic                load;

    assign bit_done = (bit_cnt_q == cnt_bits'(clks_per_bit - 1));
    assign load = (state_q == tx_idle) && start && cmd.write;
    assign ready = (state_q == tx_idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= tx_idle;
            bit_cnt_q <= '0;
            bit_idx_q <= '0;
            tx_q <= 1'b1;
            valid_q <= 1'b0;
            last_byte_q <= '0;
        end else begin
            valid_q <= start && !cmd.write;
            // bit period counter runs only while a frame is out
            if (state_q != tx_idle) begin
                bit_cnt_q <= bit_done ? '0 : bit_cnt_q + 1'b1;
            end
            case (state_q)
                tx_idle: begin
                    if (load) begin
                        state_q <= tx_start;
                        tx_q <= 1'b0;
                        last_byte_q <= cmd.wdata[7:0];
                    end
                end
                tx_start: begin
                    if (bit_done) begin
                        state_q <= tx_data;
                        tx_q <= shift_q[0];
                        bit_idx_q <= '0;
                    end
                end
                tx_data: begin
                    if (bit_done) begin
                        if (bit_idx_q == 3'd7) begin
                            state_q <= tx_stop;
                            tx_q <= 1'b1;
                        end else begin
                            tx_q <= shift_q[0];
                            bit_idx_q <= bit_idx_q + 3'd1;
                        end
                    end
                end
                tx_stop: begin
                    if (bit_done) begin
                        state_q <= tx_idle;
                    end
                end
                default: state_q <= tx_idle;
            endcase
        end
    end

    // lsb first, shifted as each bit goes on the line
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= cmd.wdata[7:0];
        end else if ((state_q == tx_start || state_q == tx_data) && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign uart_tx = tx_q;
    assign rsp = '{rdata: {24'h0, last_byte_q}, rdata_valid: valid_q};

    // controller holds starts off while a frame is sending
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> state_q == tx_idle);

endmodule

`default_nettype wire

// File: logic/machine_timer.sv
`timescale 1ns/10ps
`default_nettype none

module machine_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  bus_pkg::bus_cmd_t cmd,
    output logic              ready,
    output bus_pkg::bus_rsp_t rsp,
    input  logic [63:0]       mtime,
    output logic [63:0]       mtimecmp
);

    import memmap_pkg::*;

    logic [3:0]  offset;
    logic [31:0] rdata_q;
    logic        valid_q;

    assign offset = cmd.addr[3:0];
    assign ready = 1'b1;

    // mtime itself lives outside, only mtimecmp is writable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp <= '1;
            valid_q <= 1'b0;
        end else begin
            valid_q <= start && !cmd.write;
            if (start && cmd.write) begin
                case (offset)
                    mtimecmp_lo_off: mtimecmp[31:0] <= cmd.wdata;
                    mtimecmp_hi_off: mtimecmp[63:32] <= cmd.wdata;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !cmd.write) begin
            case (offset)
                mtime_lo_off: rdata_q <= mtime[31:0];
                mtime_hi_off: rdata_q <= mtime[63:32];
                mtimecmp_lo_off: rdata_q <= mtimecmp[31:0];
                mtimecmp_hi_off: rdata_q <= mtimecmp[63:32];
                default: rdata_q <= '0;
            endcase
        end
    end

    assign rsp = '{rdata: rdata_q, rdata_valid: valid_q};

endmodule

`default_nettype wire

// File: logic/mmio_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_subsystem #(
    parameter int clks_per_bit = 8,
    parameter int memory_words = 1024
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_start,
    input  bus_pkg::bus_cmd_t cmd,
    output logic              cmd_ready,
    output bus_pkg::bus_rsp_t rsp,
    output logic              uart_tx,
    input  logic [63:0]       mtime,
    output logic [63:0]       mtimecmp
);

    import bus_pkg::*;

    logic     mem_start;
    bus_cmd_t mem_cmd;
    logic     mem_ready;
    bus_rsp_t mem_rsp;
    logic     uart_start;
    bus_cmd_t uart_cmd;
    logic     uart_ready;
    bus_rsp_t uart_rsp;
    logic     timer_start;
    bus_cmd_t timer_cmd;
    logic     timer_ready;
    bus_rsp_t timer_rsp;

    memory_map_controller u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (cmd_start),
        .cmd         (cmd),
        .cmd_ready   (cmd_ready),
        .rsp         (rsp),
        .mem_start   (mem_start),
        .mem_cmd     (mem_cmd),
        .mem_ready   (mem_ready),
        .mem_rsp     (mem_rsp),
        .uart_start  (uart_start),
        .uart_cmd    (uart_cmd),
        .uart_ready  (uart_ready),
        .uart_rsp    (uart_rsp),
        .timer_start (timer_start),
        .timer_cmd   (timer_cmd),
        .timer_ready (timer_ready),
        .timer_rsp   (timer_rsp)
    );

    data_memory #(
        .memory_words (memory_words)
    ) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mem_start),
        .cmd   (mem_cmd),
        .ready (mem_ready),
        .rsp   (mem_rsp)
    );

    uart_tx_port #(
        .clks_per_bit (clks_per_bit)
    ) u_uart_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (uart_start),
        .cmd     (uart_cmd),
        .ready   (uart_ready),
        .rsp     (uart_rsp),
        .uart_tx (uart_tx)
    );

    machine_timer u_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (timer_start),
        .cmd      (timer_cmd),
        .ready    (timer_ready),
        .rsp      (timer_rsp),
        .mtime    (mtime),
        .mtimecmp (mtimecmp)
    );

endmodule

`default_nettype wire

// File: bench/mmio_subsystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_subsystem_tb;

    import memmap_pkg::*;
    import bus_pkg::*;

    localparam int clks_per_bit = 8;
    localparam int mem_words = 1024;
    localparam int index_bits = $clog2(mem_words);
    localparam int ready_timeout = 12 * clks_per_bit + 16;
    localparam int start_bit_timeout = 4 * clks_per_bit;

    logic        clk;
    logic        rst_n;
    logic        cmd_start;
    bus_cmd_t    cmd;
    logic        cmd_ready;
    bus_rsp_t    rsp;
    logic        uart_tx;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;

    logic [31:0] rng;
    logic [31:0] model_mem [mem_words];
    logic [63:0] mtimecmp_model;
    logic [7:0]  uart_byte_model;

    mmio_subsystem #(
        .clks_per_bit (clks_per_bit),
        .memory_words (mem_words)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .uart_tx   (uart_tx),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // word address wraps modulo the RAM depth
    function automatic logic [index_bits-1:0] word_index(input logic [31:0] addr);
        logic [31:0] w;
        w = (addr >> 2) % 32'(mem_words);
        return w[index_bits-1:0];
    endfunction

    function automatic logic [31:0] timer_addr(input logic [3:0] off);
        return timer_base | {28'h0, off};
    endfunction

    // top bit clear keeps random addresses out of the io windows
    function automatic logic [31:0] mem_addr(input logic [31:0] raw);
        return {1'b0, raw[30:2], 2'b00};
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input bus_rsp_t got, input logic [31:0] exp, input string what);
        if (got.rdata_valid !== 1'b1) begin
            stop_on_error($sformatf("error at %0t: %s gave no valid read response",
                                    $time, what));
        end else if (got.rdata !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s, got %h, expected %h",
                                    $time, what, got.rdata, exp));
        end
    endtask

    task automatic check_wide(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s, got %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s, got %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s, got %b, expected %b",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s, got %0d cycles, expected %0d",
                                    $time, what, got, exp));
        end
    endtask

    // counts falling edges until the DUT can take a command
    task automatic wait_ready(input string what, output int waited);
        waited = 0;
        while (cmd_ready !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > ready_timeout) begin
                stop_on_error($sformatf("timeout at %0t: cmd_ready never rose for %s",
                                        $time, what));
            end
        end
    endtask

    // cmd_ready must stay low for the whole frame
    task automatic expect_busy(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (cmd_ready !== 1'b0) begin
                stop_on_error($sformatf("error at %0t: cmd_ready rose while a frame was sending",
                                        $time));
            end
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             output int waited);
        @(negedge clk);
        cmd = '{addr: addr, write: 1'b1, wdata: data};
        cmd_start = 1'b1;
        wait_ready("a write", waited);
        @(negedge clk);
        cmd_start = 1'b0;
        check_level(rsp.rdata_valid, 1'b0, "rdata_valid in the cycle after a write");
    endtask

    task automatic bus_read(input logic [31:0] addr, output bus_rsp_t r);
        int waited;
        @(negedge clk);
        cmd = '{addr: addr, write: 1'b0, wdata: 32'h0};
        cmd_start = 1'b1;
        wait_ready("a read", waited);
        @(negedge clk);
        cmd_start = 1'b0;
        r = rsp;
        @(negedge clk);
        check_level(rsp.rdata_valid, 1'b0, "rdata_valid one cycle after a response");
    endtask

    // second read is launched while the first one's response is on the port
    task automatic read_pair(input logic [31:0] addr_a, input logic [31:0] exp_a,
                             input logic [31:0] addr_b, input logic [31:0] exp_b);
        int waited;
        @(negedge clk);
        cmd = '{addr: addr_a, write: 1'b0, wdata: 32'h0};
        cmd_start = 1'b1;
        wait_ready("first read of a pair", waited);
        @(negedge clk);
        cmd = '{addr: addr_b, write: 1'b0, wdata: 32'h0};
        check_word(rsp, exp_a, "first read of a pair");
        check_level(cmd_ready, 1'b1, "cmd_ready for the second read of a pair");
        @(negedge clk);
        cmd_start = 1'b0;
        check_word(rsp, exp_b, "second read of a pair");
    endtask

    // samples the line at the middle of each bit
    task automatic uart_receive(output logic [7:0] data);
        int waited;
        waited = 0;
        data = 8'h0;
        while (uart_tx !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > start_bit_timeout) begin
                stop_on_error($sformatf("timeout at %0t: no UART start bit appeared", $time));
            end
        end
        expect_busy(clks_per_bit / 2);
        check_level(uart_tx, 1'b0, "UART start bit at its center");
        for (int i = 0; i < 8; i++) begin
            expect_busy(clks_per_bit);
            data = {uart_tx, data[7:1]};
        end
        expect_busy(clks_per_bit);
        check_level(uart_tx, 1'b1, "UART stop bit");
    endtask

    task automatic test_reset_state();
        bus_rsp_t r;
        check_level(cmd_ready, 1'b1, "cmd_ready after reset");
        check_level(rsp.rdata_valid, 1'b0, "rdata_valid after reset");
        check_level(uart_tx, 1'b1, "uart_tx idle after reset");
        check_wide(mtimecmp, mtimecmp_model, "mtimecmp after reset");
        bus_read(uart_tx_base, r);
        check_word(r, 32'h0, "UART last byte after reset");
    endtask

    task automatic test_memory();
        logic [31:0] addr_q [$];
        logic [31:0] addr;
        logic [31:0] alias_addr;
        logic [31:0] data;
        bus_rsp_t    r;
        int          waited;
        for (int i = 0; i < 8; i++) begin
            addr = mem_addr(rand_word());
            data = rand_word();
            addr_q.push_back(addr);
            model_mem[word_index(addr)] = data;
            bus_write(addr, data, waited);
        end
        foreach (addr_q[i]) begin
            bus_read(addr_q[i], r);
            check_word(r, model_mem[word_index(addr_q[i])], "memory read back");
        end
        // one RAM depth higher lands on the same word
        alias_addr = addr_q[0] + 32'(mem_words) * 32'd4;
        bus_read(alias_addr, r);
        check_word(r, model_mem[word_index(addr_q[0])], "memory read at an aliased address");
        data = rand_word();
        model_mem[word_index(alias_addr)] = data;
        bus_write(alias_addr, data, waited);
        bus_read(addr_q[0], r);
        check_word(r, data, "memory write through an aliased address");
    endtask

    task automatic test_timer();
        logic [31:0] data;
        bus_rsp_t    r;
        int          waited;
        @(negedge clk);
        mtime = {rand_word(), rand_word()};
        bus_read(timer_addr(mtime_lo_off), r);
        check_word(r, mtime[31:0], "mtime low half");
        bus_read(timer_addr(mtime_hi_off), r);
        check_word(r, mtime[63:32], "mtime high half");
        data = rand_word();
        mtimecmp_model[31:0] = data;
        bus_write(timer_addr(mtimecmp_lo_off), data, waited);
        check_wide(mtimecmp, mtimecmp_model, "mtimecmp after a low half write");
        data = rand_word();
        mtimecmp_model[63:32] = data;
        bus_write(timer_addr(mtimecmp_hi_off), data, waited);
        check_wide(mtimecmp, mtimecmp_model, "mtimecmp after a high half write");
        bus_read(timer_addr(mtimecmp_lo_off), r);
        check_word(r, mtimecmp_model[31:0], "mtimecmp low half read");
        bus_read(timer_addr(mtimecmp_hi_off), r);
        check_word(r, mtimecmp_model[63:32], "mtimecmp high half read");
        // mtime is driven from outside so a write there has no effect
        bus_write(timer_addr(mtime_lo_off), rand_word(), waited);
        check_wide(mtimecmp, mtimecmp_model, "mtimecmp after a write to mtime");
        bus_read(timer_addr(mtime_lo_off), r);
        check_word(r, mtime[31:0], "mtime low half after a write to it");
    endtask

    task automatic test_uart();
        logic [31:0] raw;
        logic [7:0]  got;
        bus_rsp_t    r;
        int          waited;
        raw = rand_word();
        uart_byte_model = raw[7:0];
        bus_write(uart_tx_base, raw, waited);
        uart_receive(got);
        check_byte(got, uart_byte_model, "decoded UART frame");
        // stop bit center sits half a bit before the frame ends
        wait_ready("the end of a UART frame", waited);
        check_count(waited, clks_per_bit - clks_per_bit / 2, "cmd_ready after the stop bit");
        bus_read(uart_tx_base, r);
        check_word(r, {24'h0, uart_byte_model}, "UART last byte read");
    endtask

    task automatic test_region_switch();
        logic [31:0] addr;
        logic [31:0] data;
        int          waited;
        addr = mem_addr(rand_word());
        data = rand_word();
        model_mem[word_index(addr)] = data;
        bus_write(addr, data, waited);
        read_pair(addr, data, uart_tx_base, {24'h0, uart_byte_model});
        read_pair(timer_addr(mtime_hi_off), mtime[63:32], addr, data);
        read_pair(uart_tx_base, {24'h0, uart_byte_model},
                  timer_addr(mtimecmp_lo_off), mtimecmp_model[31:0]);
    endtask

    task automatic test_backpressure();
        logic [31:0] addr;
        logic [31:0] old_word;
        logic [31:0] new_word;
        logic [31:0] raw;
        bus_rsp_t    r;
        int          waited;
        addr = mem_addr(rand_word());
        old_word = rand_word();
        new_word = ~old_word;
        bus_write(addr, old_word, waited);
        raw = rand_word();
        uart_byte_model = raw[7:0];
        bus_write(uart_tx_base, raw, waited);
        // start withdrawn before ready rises, so memory never sees it
        @(negedge clk);
        cmd = '{addr: addr, write: 1'b1, wdata: new_word};
        cmd_start = 1'b1;
        expect_busy(clks_per_bit);
        cmd_start = 1'b0;
        wait_ready("the end of a UART frame", waited);
        bus_read(addr, r);
        check_word(r, old_word, "memory after a start ignored under back-pressure");
        raw = rand_word();
        uart_byte_model = raw[7:0];
        bus_write(uart_tx_base, raw, waited);
        // held start is taken only when the frame ends
        bus_write(addr, new_word, waited);
        check_count(waited, 10 * clks_per_bit - 1, "memory write held off by a UART frame");
        model_mem[word_index(addr)] = new_word;
        bus_read(addr, r);
        check_word(r, new_word, "memory after a held write was accepted");
    endtask

    initial begin
        rng = 32'd33398;
        rst_n = 1'b0;
        cmd_start = 1'b0;
        cmd = '0;
        mtime = '0;
        mtimecmp_model = '1;
        uart_byte_model = 8'h0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_memory();
        test_timer();
        test_uart();
        test_region_switch();
        test_backpressure();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: mmio_subsystem.f
logic/memmap_pkg.sv
logic/bus_pkg.sv
logic/memory_map_controller.sv
logic/data_memory.sv
logic/uart_tx_port.sv
logic/machine_timer.sv
logic/mmio_subsystem.sv
bench/mmio_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := mmio_subsystem_tb
FILELIST  := mmio_subsystem.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
SOURCES   := $(wildcard logic/*.sv bench/*.sv)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
